//--- Makefile
SIM    = verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP    = tb_dequant_unit
FLIST  = list.f
BUILD  = obj_dir
LOG    = sim.log

.PHONY: all compile run clean

all: run

compile: $(BUILD)/V$(TOP)

$(BUILD)/V$(TOP): $(FLIST) $(shell cat $(FLIST))
	$(SIM) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)

# The run fails unless the log holds the pass line.
run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q -F -x '** PASS **' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- bench/tb_dequant_unit.sv
`timescale 1ns/100ps

module tb_dequant_unit;
    import fp_pkg::*;
    import qgemm_pkg::*;

    localparam int VEC_W = LANES_NUM * ACC_W;
    localparam int OUT_W = LANES_NUM * FP_DATA_W;
    // Test lengths in cycles, drain included, in the order the tests run.
    localparam int TEST_CYCLES = 4 + 206 + 67 + 8 + 202;
    localparam int TIMEOUT_NS  = TEST_CYCLES * 40 * 2 + 10 * 40;

    logic             clk;
    logic             rst_n;
    logic             scale_wr;
    scale_op_e        scale_op;
    logic [LANE_IDX_W-1:0] scale_lane;
    logic [FP_MANT_W-1:0]  scale_mant;
    logic [FP_EXP_W-1:0]   scale_exp;
    logic             acc_valid;
    logic [VEC_W-1:0] acc_vec;
    logic             r_valid;
    logic [OUT_W-1:0] r_vec;

    logic [15:0]          lfsr = 16'd71;
    logic [FP_MANT_W-1:0] model_mant [LANES_NUM];
    logic [FP_EXP_W-1:0]  model_exp  [LANES_NUM];
    logic [OUT_W-1:0]     exp_vec_q [$];
    int                   due_q [$];
    logic [OUT_W-1:0]     held_vec  = '0;   // Last result the output register should show.
    int                   sent_cnt  = 0;
    int                   recv_cnt  = 0;
    int                   cycle_cnt = 0;
    int                   test_errs = 0;
    int                   tests_ok  = 0;
    int                   tests_bad = 0;
    string                cur_test  = "reset";

    dequant_unit u_dut (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .scale_wr_i   (scale_wr),
        .scale_op_i   (scale_op),
        .scale_lane_i (scale_lane),
        .scale_mant_i (scale_mant),
        .scale_exp_i  (scale_exp),
        .acc_valid_i  (acc_valid),
        .acc_vec_i    (acc_vec),
        .r_valid_o    (r_valid),
        .r_vec_o      (r_vec)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    // Taps 16, 14, 13, 11. Each bit taken costs one step.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    // Random arithmetic shift spreads the magnitudes over the whole range.
    function automatic logic [VEC_W-1:0] rand_acc_vec();
        logic [VEC_W-1:0] v;
        for (int l = 0; l < LANES_NUM; l++) begin
            v[l*ACC_W +: ACC_W] = $signed(rand_bits(32)) >>> rand_bits(5);
        end
        return v;
    endfunction

    // Reference conversion of one accumulator times a float scale.
    function automatic logic [31:0] model_convert(input logic [31:0] acc,
                                                  input logic [22:0] mant,
                                                  input logic [7:0] expo);
        logic        sgn;
        logic [31:0] m;
        int          e;
        int          rexp;
        logic [47:0] p;
        logic [22:0] frac;
        sgn = acc[31];
        if (acc == 32'd0) return 32'd0;
        m = sgn ? ~acc + 32'd1 : acc;
        e = 31;
        while (!m[31]) begin
            m = m << 1;
            e--;
        end
        p    = 48'(m[31:8]) * 48'({1'b1, mant});   // Truncated to 24 significant bits.
        rexp = e + int'(expo);
        if (p[47]) begin
            rexp++;
            frac = p[46:24];
        end else begin
            frac = p[45:23];
        end
        if (rexp < 1) return {sgn, 31'd0};
        if (rexp > 254) return {sgn, 8'hff, 23'd0};
        return {sgn, rexp[7:0], frac};
    endfunction

    function automatic logic [OUT_W-1:0] model_vec(input logic [VEC_W-1:0] v);
        logic [OUT_W-1:0] r;
        for (int l = 0; l < LANES_NUM; l++) begin
            r[l*32 +: 32] = model_convert(v[l*ACC_W +: ACC_W], model_mant[l], model_exp[l]);
        end
        return r;
    endfunction

    // One stimulus cycle. The expected result uses the scales from before a same-cycle write.
    task automatic drive_cycle(input logic valid, input logic [VEC_W-1:0] vec,
                               input logic wr, input scale_op_e op,
                               input logic [1:0] lane, input logic [22:0] mant,
                               input logic [7:0] expo);
        @(posedge clk);
        #2;
        if (valid) begin
            exp_vec_q.push_back(model_vec(vec));
            due_q.push_back(cycle_cnt + 1);
            sent_cnt++;
        end
        if (wr) begin
            for (int l = 0; l < LANES_NUM; l++) begin
                if (op == SCALE_WR_ALL || lane == 2'(l)) begin
                    model_mant[l] = mant;
                    model_exp[l]  = expo;
                end
            end
        end
        acc_valid  = valid;
        acc_vec    = vec;
        scale_wr   = wr;
        scale_op   = op;
        scale_lane = lane;
        scale_mant = mant;
        scale_exp  = expo;
    endtask

    task automatic send_vec(input logic [VEC_W-1:0] vec);
        drive_cycle(1'b1, vec, 1'b0, SCALE_WR_LANE, 2'd0, 23'd0, 8'd127);
    endtask

    task automatic write_scale(input scale_op_e op, input logic [1:0] lane,
                               input logic [22:0] mant, input logic [7:0] expo);
        drive_cycle(1'b0, '0, 1'b1, op, lane, mant, expo);
    endtask

    // Known float32 encodings guard the model itself.
    task automatic check_model(input logic [VEC_W-1:0] vec, input logic [OUT_W-1:0] lit);
        logic [OUT_W-1:0] got;
        got = model_vec(vec);
        assert (got == lit) else begin
            $display("ERROR %s: expected %h actual %h (model)", cur_test, lit, got);
            test_errs++;
        end
    endtask

    // Inputs go idle first so that the pipeline empties.
    task automatic drain();
        drive_cycle(1'b0, '0, 1'b0, SCALE_WR_LANE, 2'd0, 23'd0, 8'd127);
        while (due_q.size() != 0) @(posedge clk);
    endtask

    task automatic finish_test();
        if (test_errs == 0) begin
            $display("test %s: ok", cur_test);
            tests_ok++;
        end else begin
            $display("test %s: %0d errors", cur_test, test_errs);
            tests_bad++;
        end
        test_errs = 0;
    endtask

    always @(negedge clk) begin : check_outputs
        logic [OUT_W-1:0] expv;
        int               due;
        if (rst_n) begin
            if (r_valid) begin
                assert (exp_vec_q.size() != 0) else begin
                    $display("test %s: r_valid_o high with no result outstanding", cur_test);
                    test_errs++;
                end
                if (exp_vec_q.size() != 0) begin
                    expv = exp_vec_q.pop_front();
                    due  = due_q.pop_front();
                    recv_cnt++;
                    held_vec = expv;
                    assert (due == cycle_cnt) else begin
                        $display("test %s: result came in cycle %0d, not %0d",
                                 cur_test, cycle_cnt, due);
                        test_errs++;
                    end
                    assert (r_vec === expv) else begin
                        $display("ERROR %s: expected %h actual %h", cur_test, expv, r_vec);
                        test_errs++;
                    end
                end
            end else begin
                assert (due_q.size() == 0 || due_q[0] > cycle_cnt) else begin
                    $display("test %s: expected result never showed up", cur_test);
                    void'(exp_vec_q.pop_front());
                    void'(due_q.pop_front());
                    test_errs++;
                end
                // The output register keeps its last result between valid cycles.
                assert (r_vec === held_vec) else begin
                    $display("ERROR %s: expected %h actual %h (held output)",
                             cur_test, held_vec, r_vec);
                    test_errs++;
                end
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired, the simulation hung in test %s.", cur_test);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        rst_n      = 1'b0;
        scale_wr   = 1'b0;
        scale_op   = SCALE_WR_LANE;
        scale_lane = '0;
        scale_mant = '0;
        scale_exp  = 8'd127;
        acc_valid  = 1'b0;
        acc_vec    = '0;
        for (int l = 0; l < LANES_NUM; l++) begin
            model_mant[l] = '0;
            model_exp[l]  = 8'd127;
        end
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;

        cur_test = "reset_defaults";
        assert (r_valid === 1'b0) else begin
            $display("r_valid_o is not low after reset");
            test_errs++;
        end
        check_model({32'd1000, 32'd255, 32'hffff_ffff, 32'd1},
                    {32'h447a_0000, 32'h437f_0000, 32'hbf80_0000, 32'h3f80_0000});
        send_vec({32'd1000, 32'd255, 32'hffff_ffff, 32'd1});
        drain();
        finish_test();

        cur_test = "per_lane_scales";
        for (int l = 0; l < LANES_NUM; l++) begin
            write_scale(SCALE_WR_LANE, 2'(l), 23'(rand_bits(23)), 8'(100 + rand_bits(5)));
        end
        repeat (200) send_vec(rand_acc_vec());
        drain();
        finish_test();

        cur_test = "broadcast";
        write_scale(SCALE_WR_ALL, 2'(rand_bits(2)), 23'(rand_bits(23)), 8'(100 + rand_bits(5)));
        repeat (64) send_vec(rand_acc_vec());
        drain();
        finish_test();

        cur_test = "edge_values";
        write_scale(SCALE_WR_ALL, 2'd0, 23'd0, 8'd127);
        check_model({32'h8000_0000, 32'd0, 32'h8000_0000, 32'd0},
                    {32'hcf00_0000, 32'd0, 32'hcf00_0000, 32'd0});
        send_vec({32'h8000_0000, 32'd0, 32'h8000_0000, 32'd0});
        write_scale(SCALE_WR_ALL, 2'd0, 23'd0, 8'd250);
        check_model({32'h8000_0001, 32'h7fff_ffff, 32'h8000_0001, 32'h7fff_ffff},
                    {32'hff80_0000, 32'h7f80_0000, 32'hff80_0000, 32'h7f80_0000});
        send_vec({32'h8000_0001, 32'h7fff_ffff, 32'h8000_0001, 32'h7fff_ffff});
        // With legal scale exponents the sum never drops below 1, so this is the flush boundary.
        write_scale(SCALE_WR_ALL, 2'd0, 23'd0, 8'd1);
        check_model({32'hffff_ffff, 32'd1, 32'hffff_ffff, 32'd1},
                    {32'h8080_0000, 32'h0080_0000, 32'h8080_0000, 32'h0080_0000});
        send_vec({32'hffff_ffff, 32'd1, 32'hffff_ffff, 32'd1});
        drain();
        finish_test();

        cur_test = "streaming";
        for (int c = 0; c < 200; c++) begin
            drive_cycle(rand_bits(2) != 0, rand_acc_vec(), rand_bits(1) == 1,
                        rand_bits(1) == 1 ? SCALE_WR_ALL : SCALE_WR_LANE,
                        2'(rand_bits(2)), 23'(rand_bits(23)), 8'(100 + rand_bits(5)));
        end
        drain();
        assert (recv_cnt == sent_cnt) else begin
            $display("Only %0d of %0d results came out of the pipeline.", recv_cnt, sent_cnt);
            test_errs++;
        end
        finish_test();

        $display("tests: %0d ok, %0d failed", tests_ok, tests_bad);
        if (tests_bad == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- design/dequant_unit.sv
`timescale 1ns/100ps

module dequant_unit (
    input  logic                                                clk_i,
    input  logic                                                rst_n_i,

    // Scale write port.
    input  logic                                                scale_wr_i,
    input  qgemm_pkg::scale_op_e                                scale_op_i,
    input  logic [qgemm_pkg::LANE_IDX_W-1:0]                    scale_lane_i,
    input  logic [fp_pkg::FP_MANT_W-1:0]                        scale_mant_i,
    input  logic [fp_pkg::FP_EXP_W-1:0]                         scale_exp_i,

    // Accumulator vector in and float vector out.
    input  logic                                                acc_valid_i,
    input  logic [qgemm_pkg::LANES_NUM*qgemm_pkg::ACC_W-1:0]    acc_vec_i,
    output logic                                                r_valid_o,
    output logic [qgemm_pkg::LANES_NUM*fp_pkg::FP_DATA_W-1:0]   r_vec_o
);
    import fp_pkg::*;
    import qgemm_pkg::*;

    logic [LANES_NUM*FP_MANT_W-1:0] mant_scale_vec;
    logic [LANES_NUM*FP_EXP_W-1:0]  exp_scale_vec;
    logic [LANES_NUM*FP_DATA_W-1:0] deq_vec;

    // A write lands at the edge so a same-cycle accumulator sees the old scale.
    scale_regs u_scale_regs (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .scale_wr_i       (scale_wr_i),
        .scale_op_i       (scale_op_i),
        .scale_lane_i     (scale_lane_i),
        .scale_mant_i     (scale_mant_i),
        .scale_exp_i      (scale_exp_i),
        .mant_scale_vec_o (mant_scale_vec),
        .exp_scale_vec_o  (exp_scale_vec)
    );

    dequantize_vector u_deq_vec (
        .acc_vec_i            (acc_vec_i),
        .mantissa_scale_vec_i (mant_scale_vec),
        .exp_scale_vec_i      (exp_scale_vec),
        .r_vec_o              (deq_vec)
    );

    // Single output stage. The data holds between valid cycles.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            r_valid_o <= 1'b0;
            r_vec_o   <= '0;
        end else begin
            r_valid_o <= acc_valid_i;
            if (acc_valid_i) begin
                r_vec_o <= deq_vec;
            end
        end
    end

    // Catches undriven accumulator bits or unset scales reaching the output.
    a_out_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        r_valid_o |-> !$isunknown(r_vec_o));

endmodule

//--- design/dequantize_elem.sv
`timescale 1ns/100ps

module dequantize_elem (
    input  logic signed [qgemm_pkg::ACC_W-1:0] acc_i,
    input  logic [fp_pkg::FP_MANT_W-1:0]       mantissa_scale_i,
    input  logic [fp_pkg::FP_EXP_W-1:0]        exp_scale_i,
    output logic [fp_pkg::FP_DATA_W-1:0]       r_data_o
);
    import fp_pkg::*;
    import qgemm_pkg::*;

    logic                         sign;
    logic                         is_zero;
    logic [ACC_W-1:0]             mag;
    logic [$clog2(ACC_W)-1:0]     lead_pos;
    logic [ACC_W-1:0]             norm;
    logic [FP_MANT_W:0]           acc_sig;
    logic [FP_MANT_W:0]           scale_sig;
    logic [2*FP_MANT_W+1:0]       prod;
    logic                         carry;
    logic [FP_MANT_W-1:0]         res_mant;
    logic [FP_EXP_W+1:0]          exp_sum;
    fp_class_e                    res_class;

    assign sign    = acc_i[ACC_W-1];
    assign is_zero = (acc_i == '0);

    // The most negative value has no positive twin but its bit pattern
    // is still the right unsigned magnitude.
    assign mag = sign ? $unsigned(-acc_i) : $unsigned(acc_i);

    // Priority search for the leading one. The highest set bit wins.
    always_comb begin
        lead_pos = '0;
        for (int b = 0; b < ACC_W; b++) begin
            if (mag[b]) begin
                lead_pos = b[$clog2(ACC_W)-1:0];
            end
        end
    end

    // Shift the leading one to the top and keep 24 bits.
    // Lower bits are simply dropped.
    assign norm    = mag << (ACC_W - 1 - lead_pos);
    assign acc_sig = norm[ACC_W-1 -: FP_MANT_W+1];

    assign scale_sig = {1'b1, mantissa_scale_i};
    assign prod      = acc_sig * scale_sig;   // Value lies in [1.0, 4.0).

    // A set top bit means the product reached 2.0.
    assign carry    = prod[2*FP_MANT_W+1];
    assign res_mant = carry ? prod[2*FP_MANT_W -: FP_MANT_W]
                            : prod[2*FP_MANT_W-1 -: FP_MANT_W];

    // The leading one position is the unbiased exponent of the accumulator.
    // The scale exponent carries the bias.
    assign exp_sum = (FP_EXP_W+2)'(lead_pos)
                   + (FP_EXP_W+2)'(exp_scale_i)
                   + (FP_EXP_W+2)'(carry);

    always_comb begin
        if (is_zero || exp_sum < 1) begin
            res_class = CLASS_ZERO;
        end else if (exp_sum > FP_EXP_MAX) begin
            res_class = CLASS_INF;
        end else begin
            res_class = CLASS_NORMAL;
        end
    end

    // Sign is already low for a zero accumulator so that case gives +0.
    always_comb begin
        case (res_class)
            CLASS_ZERO: begin
                r_data_o = {sign, {(FP_DATA_W-1){1'b0}}};
            end
            CLASS_INF: begin
                r_data_o = {sign, {FP_EXP_W{1'b1}}, {FP_MANT_W{1'b0}}};
            end
            CLASS_NORMAL: begin
                r_data_o = {sign, exp_sum[FP_EXP_W-1:0], res_mant};
            end
            default: begin
                r_data_o = '0;
            end
        endcase
    end

endmodule

//--- design/dequantize_vector.sv
`timescale 1ns/100ps

module dequantize_vector (
    input  logic [qgemm_pkg::LANES_NUM*qgemm_pkg::ACC_W-1:0]    acc_vec_i,
    input  logic [qgemm_pkg::LANES_NUM*fp_pkg::FP_MANT_W-1:0]   mantissa_scale_vec_i,
    input  logic [qgemm_pkg::LANES_NUM*fp_pkg::FP_EXP_W-1:0]    exp_scale_vec_i,
    output logic [qgemm_pkg::LANES_NUM*fp_pkg::FP_DATA_W-1:0]   r_vec_o
);
    import fp_pkg::*;
    import qgemm_pkg::*;

    genvar i;
    generate
        for (i = 0; i < LANES_NUM; i = i + 1) begin : g_lane
            logic signed [ACC_W-1:0]   acc_lane;
            logic [FP_MANT_W-1:0]      mant_lane;
            logic [FP_EXP_W-1:0]       exp_lane;
            logic [FP_DATA_W-1:0]      r_lane;

            // Lane i sits in slice i with lane 0 in the low bits.
            assign acc_lane  = acc_vec_i[i*ACC_W +: ACC_W];
            assign mant_lane = mantissa_scale_vec_i[i*FP_MANT_W +: FP_MANT_W];
            assign exp_lane  = exp_scale_vec_i[i*FP_EXP_W +: FP_EXP_W];

            dequantize_elem u_deq_lane (
                .acc_i            (acc_lane),
                .mantissa_scale_i (mant_lane),
                .exp_scale_i      (exp_lane),
                .r_data_o         (r_lane)
            );

            assign r_vec_o[i*FP_DATA_W +: FP_DATA_W] = r_lane;
        end
    endgenerate

endmodule

//--- design/fp_pkg.sv
package fp_pkg;

    // IEEE-754 single precision layout.
    localparam int FP_DATA_W = 32;
    localparam int FP_MANT_W = 23;   // Stored bits only, the hidden one is implied.
    localparam int FP_EXP_W  = 8;

    localparam int FP_EXP_BIAS = 127;

    // All ones in the exponent field is kept for infinity.
    localparam int FP_EXP_MAX = 254;

    // Result class of one converted lane.
    // It picks how sign, exponent and mantissa are packed.
    typedef enum logic [1:0] {
        CLASS_ZERO,
        CLASS_NORMAL,
        CLASS_INF
    } fp_class_e;

endpackage

//--- design/qgemm_pkg.sv
package qgemm_pkg;

    localparam int LANES_NUM  = 4;
    localparam int LANE_IDX_W = 2;

    // Operand width of the quantized GEMM.
    localparam int BIT_NUM = 8;

    // An 8x8 product fills 16 bits and the remaining 16 bits are headroom
    // for summing along the reduction dimension.
    localparam int ACC_W = 4 * BIT_NUM;

    // Scale write opcodes.
    typedef enum logic [0:0] {
        SCALE_WR_LANE,   // Only the lane given by scale_lane_i is written.
        SCALE_WR_ALL     // Every lane takes the same scale.
    } scale_op_e;

endpackage

//--- design/scale_regs.sv
`timescale 1ns/100ps

module scale_regs (
    input  logic                                               clk_i,
    input  logic                                               rst_n_i,
    input  logic                                               scale_wr_i,
    input  qgemm_pkg::scale_op_e                               scale_op_i,
    input  logic [qgemm_pkg::LANE_IDX_W-1:0]                   scale_lane_i,
    input  logic [fp_pkg::FP_MANT_W-1:0]                       scale_mant_i,
    input  logic [fp_pkg::FP_EXP_W-1:0]                        scale_exp_i,
    output logic [qgemm_pkg::LANES_NUM*fp_pkg::FP_MANT_W-1:0]  mant_scale_vec_o,
    output logic [qgemm_pkg::LANES_NUM*fp_pkg::FP_EXP_W-1:0]   exp_scale_vec_o
);
    import fp_pkg::*;
    import qgemm_pkg::*;

    logic [FP_MANT_W-1:0] mant_q [LANES_NUM];
    logic [FP_EXP_W-1:0]  exp_q  [LANES_NUM];
    logic [LANES_NUM-1:0] lane_sel;

    // One-hot lane select, or all lanes for a broadcast.
    always_comb begin
        lane_sel = '0;
        if (scale_wr_i) begin
            if (scale_op_i == SCALE_WR_ALL) begin
                lane_sel = '1;
            end else begin
                lane_sel[scale_lane_i] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int l = 0; l < LANES_NUM; l++) begin
                mant_q[l] <= '0;                        // Scale of 1.0 after reset.
                exp_q[l]  <= FP_EXP_W'(FP_EXP_BIAS);
            end
        end else begin
            for (int l = 0; l < LANES_NUM; l++) begin
                if (lane_sel[l]) begin
                    mant_q[l] <= scale_mant_i;
                    exp_q[l]  <= scale_exp_i;
                end
            end
        end
    end

    always_comb begin
        for (int l = 0; l < LANES_NUM; l++) begin
            mant_scale_vec_o[l*FP_MANT_W +: FP_MANT_W] = mant_q[l];
            exp_scale_vec_o[l*FP_EXP_W +: FP_EXP_W]    = exp_q[l];
        end
    end

    // Lanes have no path for infinite or subnormal scales.
    a_no_inf_scale: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        scale_wr_i |-> scale_exp_i != '1);

    a_no_sub_scale: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        scale_wr_i |-> scale_exp_i != '0);

endmodule

//--- list.f
design/fp_pkg.sv
design/qgemm_pkg.sv
design/dequantize_elem.sv
design/dequantize_vector.sv
design/scale_regs.sv
design/dequant_unit.sv
bench/tb_dequant_unit.sv
